// ==== src/zet_cfg.svh ====
`ifndef ZET_CFG_SVH
`define ZET_CFG_SVH

// datapath widths
`define BYTE_W 8
`define WORD_W 16
`define ADDR_W 20
`define SEL_W 4

// real mode segment to physical shift
`define SEG_SHIFT 4

`define REG_NONE 4'd12 // selector that addresses no register
`define OP_NOP 8'h90

// ip step per fetch cycle
`define STEP_BYTE 16'd1
`define STEP_WORD 16'd2

`endif

// ==== src/x86_pkg.sv ====
`default_nettype none

`include "zet_cfg.svh"

package x86_pkg;

  typedef logic [`BYTE_W-1:0] byte_t;  // one instruction byte
  typedef logic [`WORD_W-1:0] word_t;  // data, ip, cs, offset, immediate
  typedef logic [`ADDR_W-1:0] paddr_t; // physical address

  // 0-7 ax cx dx bx sp bp si di, 8-11 es cs ss ds
  typedef logic [`SEL_W-1:0] reg_sel_t;

  // modrm sub-fields
  typedef logic [1:0] mod_t;
  typedef logic [2:0] rm_t;

endpackage

`default_nettype wire

// ==== src/seq_pkg.sv ====
`default_nettype none

package seq_pkg;

  // microcode entry point, one per instruction form
  typedef enum logic [5:0] {
    NOP,
    PUSHR,
    POPR,
    POPM,
    MOVRRB, MOVRRW,
    MOVRMB, MOVRMW,
    MOVMRB, MOVMRW,
    MOVIRB, MOVIRW,
    MOVIMB, MOVIMW,
    MOVMAB, MOVMAW,
    MOVAMB, MOVAMW,
    XCHRRB, XCHRRW,
    XCHRMB, XCHRMW,
    LEA,
    LES,
    LDS,
    PUSHF, POPF, SAHF, LAHF,
    CMC, CLC, STC, CLI, STI, CLD, STD,
    XLAT,
    INIB, INIW,
    INRB, INRW,
    OUTIB, OUTIW,
    OUTRB, OUTRW,
    JMPI,
    LJMPI,
    HLT
  } seq_entry_e;

  typedef enum logic [2:0] {
    OPCODE,
    MODRM,
    OFFSET,
    IMMED,
    EXEC
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== src/decode_if.sv ====
`default_nettype none

interface decode_if
  import x86_pkg::*, seq_pkg::*;
(
  input logic clk
);
  byte_t      opcode;
  byte_t      modrm;
  logic       need_modrm;
  logic       need_off;
  logic       need_imm;
  logic       off_size; // 1 for a word field
  logic       imm_size;
  seq_entry_e seq;
  reg_sel_t   src;
  reg_sel_t   dst;
  reg_sel_t   base;
  reg_sel_t   index;

  modport fsm (
    output opcode, modrm,
    input  need_modrm, need_off, need_imm, off_size, imm_size,
    input  seq, src, dst, base, index
  );

  modport deco (
    input  clk, opcode, modrm,
    output need_modrm, need_off, need_imm, off_size, imm_size,
    output seq, src, dst, base, index
  );
endinterface

`default_nettype wire

// ==== src/memory_regs.sv ====
`default_nettype none

`include "zet_cfg.svh"

module memory_regs
  import x86_pkg::*;
(
  input  rm_t      rm_i,
  input  mod_t     mod_i,
  output reg_sel_t base_o,
  output reg_sel_t index_o
);

  always_comb
  begin
    case (rm_i)
      3'b000:
      begin
        base_o  = 4'd3; // bx + si
        index_o = 4'd6;
      end
      3'b001:
      begin
        base_o  = 4'd3; // bx + di
        index_o = 4'd7;
      end
      3'b010:
      begin
        base_o  = 4'd5; // bp + si
        index_o = 4'd6;
      end
      3'b011:
      begin
        base_o  = 4'd5; // bp + di
        index_o = 4'd7;
      end
      3'b100:
      begin
        base_o  = `REG_NONE;
        index_o = 4'd6;
      end
      3'b101:
      begin
        base_o  = `REG_NONE;
        index_o = 4'd7;
      end
      3'b110:
      begin
        base_o  = (mod_i != 2'b00) ? 4'd5 : `REG_NONE; // mod 00 is direct address
        index_o = `REG_NONE;
      end
      default:
      begin
        base_o  = 4'd3; // bx alone
        index_o = `REG_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/opcode_deco.sv ====
`default_nettype none

`include "zet_cfg.svh"

module opcode_deco
  import x86_pkg::*, seq_pkg::*;
(
  decode_if.deco dec
);
  mod_t       mod;
  logic [2:0] regm;
  rm_t        rm;
  logic       d;
  logic       b;
  logic       mem;
  logic [2:0] srcm;
  logic [2:0] dstm;
  logic       direct;
  logic       need_off_mod;
  logic       off_size_mod;
  reg_sel_t   mr_base;
  reg_sel_t   mr_index;
  reg_sel_t   ea_base;
  reg_sel_t   ea_index;

  assign mod  = dec.modrm[7:6];
  assign regm = dec.modrm[5:3];
  assign rm   = dec.modrm[2:0];
  assign d    = dec.opcode[1]; // reg field is the destination
  assign b    = ~dec.opcode[0];
  assign mem  = (mod != 2'b11);
  assign srcm = d ? rm : regm;
  assign dstm = d ? regm : rm;

  memory_regs i_memory_regs (
    .rm_i    (rm),
    .mod_i   (mod),
    .base_o  (mr_base),
    .index_o (mr_index)
  );

  assign direct       = (mr_base == `REG_NONE) && (mr_index == `REG_NONE);
  assign need_off_mod = direct | (mod == 2'b01) | (mod == 2'b10);
  assign off_size_mod = direct | (mod == 2'b10); // disp16 or direct address
  assign ea_base      = mem ? mr_base : `REG_NONE;
  assign ea_index     = mem ? mr_index : `REG_NONE;

  always_comb
  begin
    dec.need_modrm = 1'b0;
    dec.need_off   = 1'b0;
    dec.need_imm   = 1'b0;
    dec.off_size   = 1'b0;
    dec.imm_size   = 1'b0;
    dec.seq        = NOP;
    dec.src        = `REG_NONE;
    dec.dst        = `REG_NONE;
    dec.base       = `REG_NONE;
    dec.index      = `REG_NONE;

    casez (dec.opcode)
      8'b000?_?110:
      begin
        dec.seq = PUSHR; // push seg
        dec.src = {2'b10, dec.opcode[4:3]};
      end
      8'b000?_?111:
      begin
        dec.seq = POPR; // pop seg
        dec.dst = {2'b10, dec.opcode[4:3]};
      end
      8'b0101_0???:
      begin
        dec.seq = PUSHR;
        dec.src = {1'b0, dec.opcode[2:0]};
      end
      8'b0101_1???:
      begin
        dec.seq = POPR;
        dec.dst = {1'b0, dec.opcode[2:0]};
      end
      8'b1000_011?:
      begin
        dec.need_modrm = 1'b1; // xchg r/m
        dec.seq = mem ? (b ? XCHRMB : XCHRMW) : (b ? XCHRRB : XCHRRW);
        dec.src = {1'b0, srcm};
        dec.dst = {1'b0, dstm};
      end
      8'b1000_10??:
      begin
        dec.need_modrm = 1'b1;
        if (mem && !d)
        begin
          dec.seq = b ? MOVRMB : MOVRMW;
          dec.src = {1'b0, srcm};
        end
        else if (mem)
        begin
          dec.seq = b ? MOVMRB : MOVMRW;
          dec.dst = {1'b0, dstm};
        end
        else
        begin
          dec.seq = b ? MOVRRB : MOVRRW;
          dec.src = {1'b0, srcm};
          dec.dst = {1'b0, dstm};
        end
      end
      8'b1000_1100:
      begin
        dec.need_modrm = 1'b1; // sreg to r/m
        dec.seq = mem ? MOVRMW : MOVRRW;
        dec.src = {1'b1, srcm};
        dec.dst = mem ? `REG_NONE : {1'b0, dstm};
      end
      8'b1000_1101:
      begin
        dec.need_modrm = 1'b1;
        dec.seq = LEA;
        dec.src = {1'b0, srcm};
      end
      8'b1000_1110:
      begin
        dec.need_modrm = 1'b1; // r/m to sreg
        dec.seq = mem ? MOVMRW : MOVRRW;
        dec.dst = {1'b1, dstm};
        dec.src = mem ? `REG_NONE : {1'b0, srcm};
      end
      8'b1000_1111:
      begin
        dec.need_modrm = 1'b1;
        dec.seq = mem ? POPM : POPR;
        dec.dst = mem ? `REG_NONE : {1'b0, rm};
      end
      8'b1001_0000: dec.seq = NOP;
      8'b1001_0???:
      begin
        dec.seq = XCHRRW; // xchg with ax
        dec.src = 4'd0;
        dec.dst = {1'b0, dec.opcode[2:0]};
      end
      8'b1001_1100: dec.seq = PUSHF;
      8'b1001_1101: dec.seq = POPF;
      8'b1001_1110: dec.seq = SAHF;
      8'b1001_1111: dec.seq = LAHF;
      8'b1010_000?:
      begin
        dec.seq = b ? MOVMAB : MOVMAW; // moffs to acc
        dec.need_off = 1'b1;
        dec.off_size = 1'b1;
      end
      8'b1010_001?:
      begin
        dec.seq = b ? MOVAMB : MOVAMW;
        dec.need_off = 1'b1;
        dec.off_size = 1'b1;
      end
      8'b1011_????:
      begin
        dec.seq = dec.opcode[3] ? MOVIRW : MOVIRB;
        dec.dst = {1'b0, dec.opcode[2:0]};
        dec.need_imm = 1'b1;
        dec.imm_size = dec.opcode[3];
      end
      8'b1100_010?:
      begin
        dec.need_modrm = 1'b1;
        dec.seq = dec.opcode[0] ? LDS : LES;
        dec.src = {1'b0, srcm};
      end
      8'b1100_011?:
      begin
        dec.need_modrm = 1'b1; // imm to r/m
        dec.seq = mem ? (b ? MOVIMB : MOVIMW) : (b ? MOVIRB : MOVIRW);
        dec.dst = mem ? `REG_NONE : {1'b0, rm};
        dec.need_imm = 1'b1;
        dec.imm_size = ~b;
      end
      8'b1101_0111: dec.seq = XLAT;
      8'b1110_01??:
      begin
        if (dec.opcode[1])
          dec.seq = b ? OUTIB : OUTIW;
        else
          dec.seq = b ? INIB : INIW;
        dec.need_imm = 1'b1; // port number byte
      end
      8'b1110_10?1:
      begin
        dec.seq = JMPI; // rel16 or rel8
        dec.need_imm = 1'b1;
        dec.imm_size = ~dec.opcode[1];
      end
      8'b1110_1010:
      begin
        dec.seq = LJMPI; // ip in offset, cs in immediate
        dec.need_off = 1'b1;
        dec.off_size = 1'b1;
        dec.need_imm = 1'b1;
        dec.imm_size = 1'b1;
      end
      8'b1110_110?: dec.seq = b ? INRB : INRW;
      8'b1110_111?: dec.seq = b ? OUTRB : OUTRW;
      8'b1111_0100: dec.seq = HLT;
      8'b1111_0101: dec.seq = CMC;
      8'b1111_1000: dec.seq = CLC;
      8'b1111_1001: dec.seq = STC;
      8'b1111_1010: dec.seq = CLI;
      8'b1111_1011: dec.seq = STI;
      8'b1111_1100: dec.seq = CLD;
      8'b1111_1101: dec.seq = STD;
      default: dec.seq = NOP;
    endcase

    // every modrm form shares the addressing fields
    if (dec.need_modrm)
    begin
      dec.need_off = need_off_mod;
      dec.off_size = off_size_mod;
      dec.base     = ea_base;
      dec.index    = ea_index;
    end
  end

  a_imm_size_needs_imm : assert property (@(posedge dec.clk) dec.imm_size |-> dec.need_imm);

endmodule

`default_nettype wire

// ==== src/fetch_fsm.sv ====
`default_nettype none

`include "zet_cfg.svh"

module fetch_fsm
  import x86_pkg::*, seq_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  word_t      data_i,
  decode_if.fsm      dec,
  output logic       bytefetch_o,
  output logic       fetch_or_exec_o,
  output word_t      imm_o,
  output word_t      off_o,
  output seq_entry_e seq_o,
  output reg_sel_t   src_o,
  output reg_sel_t   dst_o,
  output reg_sel_t   base_o,
  output reg_sel_t   index_o
);
  fetch_state_e state;
  fetch_state_e next_state;
  byte_t        opcode_l;
  byte_t        modrm_l;
  word_t        off_l;
  word_t        imm_l;
  logic         word_step;
  word_t        field;

  // decoder sees the live byte in its own state
  assign dec.opcode = (state == OPCODE) ? data_i[7:0] : opcode_l;
  assign dec.modrm  = (state == MODRM) ? data_i[7:0] : modrm_l;

  assign word_step = ((state == OFFSET) && dec.off_size) ||
                     ((state == IMMED) && dec.imm_size);
  assign field     = word_step ? data_i : {8'h00, data_i[7:0]};

  always_comb
  begin
    case (state)
      OPCODE:
        next_state = dec.need_modrm ? MODRM :
                     dec.need_off   ? OFFSET :
                     dec.need_imm   ? IMMED : EXEC;
      MODRM:
        next_state = dec.need_off ? OFFSET : (dec.need_imm ? IMMED : EXEC);
      OFFSET:
        next_state = dec.need_imm ? IMMED : EXEC;
      IMMED:
        next_state = EXEC;
      default:
        next_state = OPCODE; // exec is a single cycle
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= OPCODE;
      opcode_l <= `OP_NOP;
    end
    else
    begin
      state <= next_state;
      case (state)
        OPCODE:
        begin
          opcode_l <= data_i[7:0];
          off_l    <= '0;
          imm_l    <= '0;
        end
        MODRM:   modrm_l <= data_i[7:0];
        OFFSET:  off_l <= field;
        IMMED:   imm_l <= field;
        default: ;
      endcase
    end
  end

  assign fetch_or_exec_o = (state == EXEC);
  assign bytefetch_o     = ~word_step;
  assign imm_o = (state == EXEC) ? imm_l : (word_step ? `STEP_WORD : `STEP_BYTE);
  assign off_o = off_l;

  assign seq_o   = dec.seq;
  assign src_o   = dec.src;
  assign dst_o   = dec.dst;
  assign base_o  = dec.base;
  assign index_o = dec.index;

  a_state_legal : assert property (@(posedge clk) disable iff (rst)
    state inside {OPCODE, MODRM, OFFSET, IMMED, EXEC});

  a_exec_single : assert property (@(posedge clk) disable iff (rst)
    fetch_or_exec_o |=> !fetch_or_exec_o);

endmodule

`default_nettype wire

// ==== src/decode_top.sv ====
`default_nettype none

`include "zet_cfg.svh"

module decode_top
  import x86_pkg::*, seq_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  word_t      cs_i,
  input  word_t      ip_i,
  input  word_t      data_i,
  output paddr_t     pc_o,
  output logic       bytefetch_o,
  output logic       fetch_or_exec_o,
  output word_t      imm_o,
  output word_t      off_o,
  output seq_entry_e seq_o,
  output reg_sel_t   src_o,
  output reg_sel_t   dst_o,
  output reg_sel_t   base_o,
  output reg_sel_t   index_o
);

  // wraps at 1 MB like the 8086
  assign pc_o = (paddr_t'(cs_i) << `SEG_SHIFT) + paddr_t'(ip_i);

  decode_if dec_bus (
    .clk (clk)
  );

  fetch_fsm i_fetch_fsm (
    .clk             (clk),
    .rst             (rst),
    .data_i          (data_i),
    .dec             (dec_bus),
    .bytefetch_o     (bytefetch_o),
    .fetch_or_exec_o (fetch_or_exec_o),
    .imm_o           (imm_o),
    .off_o           (off_o),
    .seq_o           (seq_o),
    .src_o           (src_o),
    .dst_o           (dst_o),
    .base_o          (base_o),
    .index_o         (index_o)
  );

  opcode_deco i_opcode_deco (
    .dec (dec_bus)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock
#(
  parameter int HALF_PERIOD = 50 // 100 ns period
)
(
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 1ns;

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== tests/decode_tb.sv ====
`default_nettype none

module decode_tb
  import x86_pkg::*, seq_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int N_INSTR     = 18;
  localparam int COLS        = 15; // 6 bytes, len, cycles, seq, 4 selectors, off, imm
  localparam int MEM_BYTES   = 256;
  localparam int CYCLE_LIMIT = 16 + 8 * N_INSTR + 20;

  logic       clk;
  logic       rst;
  word_t      cs;
  word_t      ip;
  word_t      data;
  paddr_t     pc;
  logic       bytefetch;
  logic       fetch_or_exec;
  word_t      imm;
  word_t      off;
  seq_entry_e seq;
  reg_sel_t   src_sel;
  reg_sel_t   dst_sel;
  reg_sel_t   base_sel;
  reg_sel_t   index_sel;

  logic [15:0] trace [0:N_INSTR*COLS-1];
  byte_t       mem [0:MEM_BYTES-1];
  word_t       ip_model;
  word_t       cs_model;
  int          seed;
  int          err_cnt;
  int          pass_cnt;
  int          cycle_cnt = 0;
  logic        instr_bad;

  tb_clock i_tb_clock (
    .clk_o (clk)
  );

  decode_top i_decode_top (
    .clk             (clk),
    .rst             (rst),
    .cs_i            (cs),
    .ip_i            (ip),
    .data_i          (data),
    .pc_o            (pc),
    .bytefetch_o     (bytefetch),
    .fetch_or_exec_o (fetch_or_exec),
    .imm_o           (imm),
    .off_o           (off),
    .seq_o           (seq),
    .src_o           (src_sel),
    .dst_o           (dst_sel),
    .base_o          (base_sel),
    .index_o         (index_sel)
  );

  // little-endian word at ip, memory wraps at 256 bytes
  function automatic word_t word_at(word_t addr);
    byte_t next_a;
    next_a = addr[7:0] + 8'd1;
    return {mem[next_a], mem[addr[7:0]]};
  endfunction

  function automatic paddr_t phys_addr(word_t seg, word_t ofs);
    return {seg, 4'h0} + {4'h0, ofs};
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    err_cnt++;
    instr_bad = 1'b1;
  endtask

  task automatic expect_hex(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      err_cnt++;
      instr_bad = 1'b1;
    end
  endtask

  task automatic check_pc();
    if (pc !== phys_addr(cs_model, ip_model))
    begin
      $display("Mismatch pc_o: got %h, expected %h", pc, phys_addr(cs_model, ip_model));
      err_cnt++;
      instr_bad = 1'b1;
    end
  endtask

  task automatic check_reset_outputs();
    expect_hex("fetch_or_exec_o", 16'(fetch_or_exec), 16'h0000);
    expect_hex("bytefetch_o", 16'(bytefetch), 16'h0001);
    expect_hex("imm_o", imm, 16'h0001);
  endtask

  task automatic load_program();
    int a;
    int k;
    int j;
    int len;
    int pos;
    for (a = 0; a < MEM_BYTES; a++)
      mem[a] = byte_t'(a) ^ 8'h5a; // background, never fetched
    $readmemh("tests/decode_trace.txt", trace);
    if ($isunknown(trace[(N_INSTR-1)*COLS + 6]) || trace[(N_INSTR-1)*COLS + 6] == 16'd0)
      report_failure("trace file holds fewer rows than expected");
    pos = 0;
    for (k = 0; k < N_INSTR; k++)
    begin
      len = int'(trace[k * COLS + 6]);
      for (j = 0; j < len; j++)
      begin
        mem[pos] = trace[k * COLS + j][7:0];
        pos++;
      end
    end
  endtask

  task automatic run_instruction(input int k);
    int    col;
    int    len;
    int    want_cycles;
    int    fetch_cycles;
    word_t ip_start;
    word_t advance;
    word_t step;
    logic  done;
    string seq_name;
    col          = k * COLS;
    len          = int'(trace[col + 6]);
    want_cycles  = int'(trace[col + 7]);
    fetch_cycles = 0;
    ip_start     = ip_model;
    done         = 1'b0;
    instr_bad    = 1'b0;
    while (!done)
    begin
      @(negedge clk);
      check_pc();
      if (fetch_or_exec)
      begin
        done     = 1'b1;
        seq_name = seq.name();
        expect_hex("seq_o", 16'(seq), trace[col + 8]);
        expect_hex("src_o", 16'(src_sel), trace[col + 9]);
        expect_hex("dst_o", 16'(dst_sel), trace[col + 10]);
        expect_hex("base_o", 16'(base_sel), trace[col + 11]);
        expect_hex("index_o", 16'(index_sel), trace[col + 12]);
        expect_hex("off_o", off, trace[col + 13]);
        expect_hex("imm_o", imm, trace[col + 14]);
      end
      else
      begin
        if (k == 0 && fetch_cycles == 0)
          check_reset_outputs(); // first cycle out of reset
        step = imm;
        if (step != 16'd1 && step != 16'd2)
          report_failure($sformatf("instruction %0d asked for an ip step of %0d", k, step));
        expect_hex("bytefetch_o", 16'(bytefetch), 16'(step == 16'd1));
        fetch_cycles++;
        @(posedge clk);
        ip_model = ip_model + step;
        ip   <= ip_model;
        data <= word_at(ip_model);
      end
    end
    advance = ip_model - ip_start;
    if (fetch_cycles != want_cycles)
      report_failure($sformatf("instruction %0d took %0d fetch cycles instead of %0d",
                               k, fetch_cycles, want_cycles));
    if (advance != word_t'(len))
      report_failure($sformatf("instruction %0d moved ip by %0d bytes instead of %0d",
                               k, advance, len));
    $display("instr %0d (%s): %s", k, seq_name, instr_bad ? "FAIL" : "ok");
    if (!instr_bad)
      pass_cnt++;
    @(posedge clk); // exec edge, next opcode cycle starts
    cs_model = word_t'($random(seed));
    cs <= cs_model;
  endtask

  initial
  begin
    int k;
    seed      = 32'h0b25_b465;
    err_cnt   = 0;
    pass_cnt  = 0;
    instr_bad = 1'b0;
    load_program();
    ip_model = '0;
    cs_model = word_t'($random(seed));
    rst      = 1'b1;
    cs       = cs_model;
    ip       = ip_model;
    data     = word_at(ip_model);
    repeat (16)
    begin
      @(posedge clk);
      @(negedge clk);
      check_reset_outputs();
      check_pc();
    end
    $display("reset: %s", instr_bad ? "FAIL" : "ok");
    if (!instr_bad)
      pass_cnt++;
    @(posedge clk);
    rst <= 1'b0;
    for (k = 0; k < N_INSTR; k++)
      run_instruction(k);
    $display("%0d of %0d tests passed, %0d errors", pass_cnt, N_INSTR + 1, err_cnt);
    if (err_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("timeout: no result after %0d cycles", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tests/decode_trace.txt ====
// b0 b1 b2 b3 b4 b5 len fetch_cycles seq src dst base index off imm
// unused bytes are 00, seq is the entry point code, selector c means no register
50 00 00 00 00 00 1 1 01 0 c c c 0000 0000
1f 00 00 00 00 00 1 1 02 c b c c 0000 0000
89 d8 00 00 00 00 2 2 05 3 0 c c 0000 0000
8b 46 fe 00 00 00 3 3 09 c 0 5 c 00fe 0000
88 87 34 12 00 00 4 3 06 0 c 3 c 1234 0000
a1 00 20 00 00 00 3 2 0f c c c c 2000 0000
a2 34 12 00 00 00 3 2 10 c c c c 1234 0000
b0 7f 00 00 00 00 2 2 0a c 0 c c 0000 007f
bb 34 12 00 00 00 3 2 0b c 3 c c 0000 1234
c7 06 00 10 cd ab 6 4 0d c c c c 1000 abcd
c6 40 05 aa 00 00 4 4 0c c c 3 6 0005 00aa
87 d9 00 00 00 00 2 2 13 1 3 c c 0000 0000
8d 5e 02 00 00 00 3 3 16 3 c 5 c 0002 0000
c4 1e 00 30 00 00 4 3 17 3 c c c 3000 0000
8e d8 00 00 00 00 2 2 05 0 b c c 0000 0000
e4 60 00 00 00 00 2 2 25 c c c c 0000 0060
ea 00 01 00 f0 00 5 3 2e c c c c 0100 f000
ff 00 00 00 00 00 1 1 00 c c c c 0000 0000

// ==== files.f ====
+incdir+src
src/x86_pkg.sv
src/seq_pkg.sv
src/decode_if.sv
src/memory_regs.sv
src/opcode_deco.sv
src/fetch_fsm.sv
src/decode_top.sv
tests/tb_clock.sv
tests/decode_tb.sv

// ==== Makefile ====
TOP = decode_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Finished with no errors'

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
